// File: hdl/saci_macros.svh
`ifndef SACI_MACROS_SVH
`define SACI_MACROS_SVH

// ------------------------------
// Widths
// ------------------------------

// Data and address word
`define SACI_WORD_W 8

// One bit per display segment, a to g
`define SACI_SEG_W 7

// ------------------------------
// Memory map
// ------------------------------

// Address bit that switches reads and writes to the RAM byte
`define SACI_RAM_BIT 7

// Program ROM index bits, 8 words aliased below 0x80
`define SACI_ROM_AW 3

// ------------------------------
// Instruction codes, upper nibble of a word
// ------------------------------
`define SACI_OP_HLT 4'hF
`define SACI_OP_STA 4'h1
`define SACI_OP_LDA 4'h2
`define SACI_OP_ADD 4'h3

`endif

// File: hdl/saci_pkg.sv
`include "saci_macros.svh"

package saci_pkg;

    // Data bus and address bus share one width
    typedef logic [`SACI_WORD_W-1:0] word_t;

    // Segment a in the top bit, segment g in bit 0, active high
    typedef logic [`SACI_SEG_W-1:0] seg_t;

    // Controller states
    // Fetch twice, then one execute state per instruction
    typedef enum logic [2:0] {
        ST_FETCH_OP   = 3'd0,
        ST_FETCH_ADDR = 3'd1,
        ST_EXEC_LDA   = 3'd2,
        ST_EXEC_ADD   = 3'd3,
        ST_EXEC_STA   = 3'd4
    } state_t;

    // Translated opcode
    // Unknown codes fold into HLT
    typedef enum logic [1:0] {
        OP_HLT = 2'd0,
        OP_STA = 2'd1,
        OP_LDA = 2'd2,
        OP_ADD = 2'd3
    } op_t;

endpackage

// File: hdl/hex_to_seg.sv
module hex_to_seg (
    input  logic [3:0]     nibble,
    output saci_pkg::seg_t seg
);

    // Active-high abcdefg, segment a in the top bit
    always_comb begin
        case (nibble)
            4'h0: seg = 7'h7E;
            4'h1: seg = 7'h30;
            4'h2: seg = 7'h6D;
            4'h3: seg = 7'h79;
            4'h4: seg = 7'h33;
            4'h5: seg = 7'h5B;
            4'h6: seg = 7'h5F;
            4'h7: seg = 7'h70;
            4'h8: seg = 7'h7F;
            4'h9: seg = 7'h7B;
            // Letters, lower case b and d
            4'hA: seg = 7'h77;
            4'hB: seg = 7'h1F;
            4'hC: seg = 7'h4E;
            4'hD: seg = 7'h3D;
            4'hE: seg = 7'h4F;
            4'hF: seg = 7'h47;
            default: seg = '0;
        endcase
    end

endmodule

// File: hdl/saci_control.sv
`include "saci_macros.svh"

module saci_control (
    input  logic             clk,
    input  logic             rst,
    input  saci_pkg::word_t  mem_rdata,
    output logic             addr_from_pc,
    output logic             rem_en,
    output logic             ac_en,
    output logic             alu_add,
    output logic             mem_write,
    output logic             pc_en,
    output saci_pkg::state_t state
);
    import saci_pkg::*;

    state_t state_q;
    state_t state_d;
    op_t    op_now;
    op_t    op_q;

    // Four-bit code to two-bit opcode
    function automatic op_t decode_op(input logic [3:0] code);
        op_t op;
        case (code)
            `SACI_OP_STA: op = OP_STA;
            `SACI_OP_LDA: op = OP_LDA;
            `SACI_OP_ADD: op = OP_ADD;
            // HLT and every undefined code
            default:      op = OP_HLT;
        endcase
        return op;
    endfunction

    // ------------------------------
    // Opcode translator and latch
    // ------------------------------

    // Opcode of the word on the bus, valid during opcode fetch
    assign op_now = decode_op(mem_rdata[`SACI_WORD_W-1:`SACI_WORD_W-4]);

    // Hold the opcode once the bus moves on to the operand
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_q <= OP_HLT;
        end else if (state_q == ST_FETCH_OP) begin
            op_q <= op_now;
        end
    end

    // ------------------------------
    // State register and next state
    // ------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_FETCH_OP;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        case (state_q)
            // HLT parks the machine here
            ST_FETCH_OP:   state_d = (op_now == OP_HLT) ? ST_FETCH_OP : ST_FETCH_ADDR;
            ST_FETCH_ADDR: begin
                // Dispatch on the latched opcode
                case (op_q)
                    OP_STA:  state_d = ST_EXEC_STA;
                    OP_LDA:  state_d = ST_EXEC_LDA;
                    OP_ADD:  state_d = ST_EXEC_ADD;
                    default: state_d = ST_FETCH_OP;
                endcase
            end
            ST_EXEC_LDA,
            ST_EXEC_ADD,
            ST_EXEC_STA:   state_d = ST_FETCH_OP;
            // Undefined encodings recover to opcode fetch
            default:       state_d = ST_FETCH_OP;
        endcase
    end

    // ------------------------------
    // Control outputs
    // ------------------------------

    // Moore enables, decoded from the state alone
    assign addr_from_pc = (state_q == ST_FETCH_OP) || (state_q == ST_FETCH_ADDR);
    assign rem_en       = (state_q == ST_FETCH_ADDR);
    assign ac_en        = (state_q == ST_EXEC_LDA) || (state_q == ST_EXEC_ADD);
    assign alu_add      = (state_q == ST_EXEC_ADD);
    assign mem_write    = (state_q == ST_EXEC_STA);

    // Mealy PC enable
    // Fetch-op looks at the bus, fetch-addr at the latch
    always_comb begin
        case (state_q)
            ST_FETCH_OP:   pc_en = (op_now != OP_HLT);
            ST_FETCH_ADDR: pc_en = (op_q != OP_HLT);
            default:       pc_en = 1'b0;
        endcase
    end

    assign state = state_q;

endmodule

// File: hdl/saci_pc.sv
module saci_pc (
    input  logic            clk,
    input  logic            rst,
    input  logic            pc_en,
    output saci_pkg::word_t pc
);
    import saci_pkg::*;

    word_t pc_q;
    word_t pc_inc;

    // Incrementer wraps past 0xFF
    assign pc_inc = pc_q + word_t'(1);

    // Advance only in cycles the controller enables
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_q <= '0;
        end else if (pc_en) begin
            pc_q <= pc_inc;
        end
    end

    assign pc = pc_q;

endmodule

// File: hdl/saci_datapath.sv
module saci_datapath (
    input  logic            clk,
    input  logic            rst,
    input  saci_pkg::word_t pc,
    input  saci_pkg::word_t mem_rdata,
    input  logic            addr_from_pc,
    input  logic            rem_en,
    input  logic            ac_en,
    input  logic            alu_add,
    output saci_pkg::word_t mem_addr,
    output saci_pkg::word_t ac
);
    import saci_pkg::*;

    word_t rem_q;
    word_t ac_q;
    word_t alu_out;

    // ------------------------------
    // Memory address register
    // ------------------------------

    // Captures the operand address during fetch-addr
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rem_q <= '0;
        end else if (rem_en) begin
            rem_q <= mem_rdata;
        end
    end

    // PC during fetch, REM during execute
    assign mem_addr = addr_from_pc ? pc : rem_q;

    // ------------------------------
    // ALU and accumulator
    // ------------------------------

    // Pass for LDA, add for ADD
    // Carry out of bit 7 is dropped
    assign alu_out = alu_add ? word_t'(mem_rdata + ac_q) : mem_rdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ac_q <= '0;
        end else if (ac_en) begin
            ac_q <= alu_out;
        end
    end

    // Accumulator is also the store data
    assign ac = ac_q;

endmodule

// File: hdl/saci_memory.sv
`include "saci_macros.svh"

module saci_memory (
    input  logic            clk,
    input  logic            rst,
    input  saci_pkg::word_t mem_addr,
    input  saci_pkg::word_t wdata,
    input  logic            mem_write,
    output saci_pkg::word_t mem_rdata,
    output saci_pkg::word_t ram_q
);
    import saci_pkg::*;

    logic  ram_sel;
    word_t rom_word;
    word_t ram_byte;

    // Top half of the map goes to the RAM byte
    assign ram_sel = mem_addr[`SACI_RAM_BIT];

    // ------------------------------
    // Program ROM
    // ------------------------------

    // Only the low index bits decode, so the program repeats every 8 words
    always_comb begin
        case (mem_addr[`SACI_ROM_AW-1:0])
            3'd0: rom_word = 8'h20;  // LDA
            3'd1: rom_word = 8'h07;  //   from 7
            3'd2: rom_word = 8'h30;  // ADD
            3'd3: rom_word = 8'h07;  //   from 7
            3'd4: rom_word = 8'h10;  // STA
            3'd5: rom_word = 8'h80;  //   to 0x80
            3'd6: rom_word = 8'hF0;  // HLT
            3'd7: rom_word = 8'h05;  // Operand data
            default: rom_word = '0;
        endcase
    end

    // ------------------------------
    // RAM byte
    // ------------------------------

    // Answers to any address with the RAM bit set
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ram_byte <= '0;
        end else if (mem_write && ram_sel) begin
            ram_byte <= wdata;
        end
    end

    // Combinational read
    assign mem_rdata = ram_sel ? ram_byte : rom_word;

    // Raw RAM contents for the display
    assign ram_q = ram_byte;

endmodule

// File: hdl/saci_top.sv
`include "saci_macros.svh"

module saci_top (
    input  logic             clk,
    input  logic             rst,
    output saci_pkg::state_t state,
    output saci_pkg::seg_t   addr_seg,
    output logic             addr_msb,
    output saci_pkg::seg_t   ram_seg
);
    import saci_pkg::*;

    // Control strobes
    logic  addr_from_pc;
    logic  rem_en;
    logic  ac_en;
    logic  alu_add;
    logic  mem_write;
    logic  pc_en;

    // Buses
    word_t pc;
    word_t mem_addr;
    word_t mem_rdata;
    word_t ac;
    word_t ram_q;

    // ------------------------------
    // Processor
    // ------------------------------
    saci_control u_control (
        .clk          (clk),
        .rst          (rst),
        .mem_rdata    (mem_rdata),
        .addr_from_pc (addr_from_pc),
        .rem_en       (rem_en),
        .ac_en        (ac_en),
        .alu_add      (alu_add),
        .mem_write    (mem_write),
        .pc_en        (pc_en),
        .state        (state)
    );

    saci_pc u_pc (
        .clk   (clk),
        .rst   (rst),
        .pc_en (pc_en),
        .pc    (pc)
    );

    saci_datapath u_datapath (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .mem_rdata    (mem_rdata),
        .addr_from_pc (addr_from_pc),
        .rem_en       (rem_en),
        .ac_en        (ac_en),
        .alu_add      (alu_add),
        .mem_addr     (mem_addr),
        .ac           (ac)
    );

    // Store data comes straight from the accumulator
    saci_memory u_memory (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (mem_addr),
        .wdata     (ac),
        .mem_write (mem_write),
        .mem_rdata (mem_rdata),
        .ram_q     (ram_q)
    );

    // ------------------------------
    // Displays
    // ------------------------------

    // Low nibble of the address on the bus
    hex_to_seg addr_disp (
        .nibble (mem_addr[3:0]),
        .seg    (addr_seg)
    );

    // Low nibble of the stored result
    hex_to_seg ram_disp (
        .nibble (ram_q[3:0]),
        .seg    (ram_seg)
    );

    // Top address bit shown on its own LED
    assign addr_msb = mem_addr[`SACI_WORD_W-1];

endmodule

// File: sim/saci_tb.sv
module saci_tb;

    // ------------------------------
    // Run length and watchdog
    // ------------------------------
    localparam int PERIOD   = 10;
    localparam int RST_CYC  = 2;
    localparam int PROG_CYC = 10;
    localparam int HOLD_CYC = 20;
    localparam int N_RUNS   = 3;
    localparam int WATCHDOG = (RST_CYC + PROG_CYC + HOLD_CYC) * N_RUNS * 2 * PERIOD;

    // Active-high abcdefg for 0 to F
    localparam logic [6:0] SEG_TAB [16] = '{7'h7E, 7'h30, 7'h6D, 7'h79, 7'h33, 7'h5B,
        7'h5F, 7'h70, 7'h7F, 7'h7B, 7'h77, 7'h1F, 7'h4E, 7'h3D, 7'h4F, 7'h47};
    // Program image holding LDA 7, ADD 7, STA 0x80, HLT and the data word
    localparam logic [7:0] ROM [8] = '{8'h20, 8'h07, 8'h30, 8'h07, 8'h10, 8'h80, 8'hF0, 8'h05};
    // State trace of one pass through the program
    localparam int EXP_SEQ [10] = '{0, 1, 2, 0, 1, 3, 0, 1, 4, 0};

    logic             clk;
    logic             rst;
    saci_pkg::state_t state;
    logic [6:0]       addr_seg;
    logic             addr_msb;
    logic [6:0]       ram_seg;

    // Reference model registers
    // Model opcode uses 0 for HLT, 1 for STA, 2 for LDA and 3 for ADD
    int         m_st;
    int         m_op;
    logic [7:0] m_pc;
    logic [7:0] m_rem;
    logic [7:0] m_ac;
    logic [7:0] m_ram;

    int          err_by_test [1:6];
    int          misc_err;
    int          total_err;
    int          tests_run;
    int          mid_cycle;
    bit          in_hold;
    logic [31:0] lcg_state;

    saci_top UUT (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .addr_seg (addr_seg),
        .addr_msb (addr_msb),
        .ram_seg  (ram_seg)
    );

    always #(PERIOD / 2) clk = ~clk;

    // Only the store reaches into the RAM half of the map in this program
    store_addr_msb: assert property (@(negedge clk) disable iff (rst)
        addr_msb == (state == saci_pkg::ST_EXEC_STA))
        else begin
            $display("[FAIL] addr_msb expected 0x%0h actual 0x%0h at %0t",
                     state == saci_pkg::ST_EXEC_STA, addr_msb, $time);
            misc_err++;
        end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------

    // PC in the fetch states, REM otherwise
    function automatic logic [7:0] model_addr();
        return (m_st <= 1) ? m_pc : m_rem;
    endfunction

    // One clock edge of the machine
    task automatic model_step();
        logic [7:0] a;
        logic [7:0] rd;
        int         op_now;
        int         nxt;
        a = model_addr();
        rd = a[7] ? m_ram : ROM[a[2:0]];
        // Unknown codes count as HLT
        case (rd[7:4])
            4'h1:    op_now = 1;
            4'h2:    op_now = 2;
            4'h3:    op_now = 3;
            default: op_now = 0;
        endcase
        nxt = 0;
        case (m_st)
            0: begin
                m_op = op_now;
                if (op_now != 0) begin
                    m_pc = m_pc + 8'd1;
                    nxt = 1;
                end
            end
            1: begin
                m_rem = rd;
                if (m_op != 0) m_pc = m_pc + 8'd1;
                nxt = (m_op == 1) ? 4 : m_op;
            end
            2: m_ac = rd;
            3: m_ac = m_ac + rd;
            4: if (a[7]) m_ram = m_ac;
            default: nxt = 0;
        endcase
        m_st = nxt;
    endtask

    task automatic model_reset();
        m_st = 0;
        m_op = 0;
        m_pc = '0;
        m_rem = '0;
        m_ac = '0;
        m_ram = '0;
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_val(input int id, input string name, input logic [7:0] exp,
                             input logic [7:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s expected 0x%02h actual 0x%02h at %0t", name, exp, got, $time);
            err_by_test[id]++;
        end
    endtask

    // Compare all outputs with the model and charge each miss to its behavior
    task automatic check_outputs();
        logic [7:0] a;
        a = model_addr();
        check_val(in_hold ? 5 : 2, "state", 8'(m_st), {5'b0, state});
        check_val(in_hold ? 5 : 3, "addr_seg", {1'b0, SEG_TAB[a[3:0]]}, {1'b0, addr_seg});
        check_val(in_hold ? 5 : 3, "addr_msb", {7'b0, a[7]}, {7'b0, addr_msb});
        check_val(in_hold ? 5 : 4, "ram_seg", {1'b0, SEG_TAB[m_ram[3:0]]}, {1'b0, ram_seg});
    endtask

    // Reset values are fetch-op, address 0 and RAM 0
    task automatic check_reset_outputs(input int id);
        check_val(id, "state", 8'h00, {5'b0, state});
        check_val(id, "addr_seg", 8'h7E, {1'b0, addr_seg});
        check_val(id, "addr_msb", 8'h00, {7'b0, addr_msb});
        check_val(id, "ram_seg", 8'h7E, {1'b0, ram_seg});
    endtask

    // Sample mid-cycle and step the model before the next edge
    task automatic run_cycles(input int n, input bit check_seq);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            check_outputs();
            if (check_seq && i < PROG_CYC) check_val(2, "state", 8'(EXP_SEQ[i]), {5'b0, state});
            model_step();
        end
    endtask

    task automatic report(input int id, input string what);
        tests_run++;
        if (err_by_test[id] == 0) $display("test %0d %s: ok", id, what);
        else $display("test %0d %s: %0d errors", id, what, err_by_test[id]);
        total_err += err_by_test[id];
        err_by_test[id] = 0;
    endtask

    // Reset lands off the clock edge so outputs must drop at once
    task automatic reset_async();
        @(posedge clk);
        #1;
        rst = 1'b1;
        model_reset();
        #1;
        check_reset_outputs(6);
        repeat (RST_CYC) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic run_program(input string tag);
        run_cycles(PROG_CYC, 1'b1);
        report(2, {"state sequence", tag});
        report(3, {"address display", tag});
        report(4, {"RAM display", tag});
        in_hold = 1'b1;
        run_cycles(HOLD_CYC, 1'b0);
        // Parked on the HLT word with 0x0A stored
        check_val(5, "addr_seg", 8'h5F, {1'b0, addr_seg});
        check_val(5, "ram_seg", 8'h77, {1'b0, ram_seg});
        in_hold = 1'b0;
        report(5, {"halt hold", tag});
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        clk = 1'b0;
        rst = 1'b1;
        in_hold = 1'b0;
        misc_err = 0;
        total_err = 0;
        tests_run = 0;
        lcg_state = 32'h10c;
        foreach (err_by_test[i]) err_by_test[i] = 0;
        model_reset();
        repeat (RST_CYC) @(posedge clk);
        #1;
        rst = 1'b0;
        #1;
        check_reset_outputs(1);
        report(1, "reset values");
        run_program("");
        // Reset out of halt clears the RAM, then again partway through the program
        lcg_state = lcg_next(lcg_state);
        mid_cycle = 1 + int'((lcg_state >> 16) % 32'd8);
        reset_async();
        run_cycles(mid_cycle, 1'b1);
        reset_async();
        report(6, $sformatf("async reset after cycle %0d", mid_cycle));
        run_program(" after reset");
        total_err += misc_err;
        $display("tests run: %0d, failed checks: %0d", tests_run, total_err);
        if (total_err == 0) $display("TESTBENCH PASSED");
        else $display("TESTBENCH FAILED");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG);
        $display("Timeout: the run did not finish within %0d time units", WATCHDOG);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: saci_top.f
+incdir+hdl
hdl/saci_pkg.sv
hdl/hex_to_seg.sv
hdl/saci_control.sv
hdl/saci_pc.sv
hdl/saci_datapath.sv
hdl/saci_memory.sv
hdl/saci_top.sv
sim/saci_tb.sv

// File: Makefile
# Verilator build and run of the SACI testbench

VERILATOR ?= verilator
TOP       ?= saci_tb
FILELIST  ?= saci_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "make test: pass" || \
		{ echo "make test: fail, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
